// File: ecc_params_pkg.sv
package ecc_params_pkg;

    // ==================================================
    // arithmetic constants of the group
    // ==================================================

    // width of a residue and of the raw scalar
    localparam int REG_SIZE = 32;

    // group order q, a prime with its top bit set
    // so k+q or k+2q always lands on bit REG_SIZE
    localparam logic [REG_SIZE-1:0] GROUP_ORDER = 32'hfffffffb;

    // conditioned scalar is REG_SIZE+1 bits wide
    // its msb is always one, ladder walks every bit of it
    localparam int LADDER_BITS = REG_SIZE + 1;

endpackage

// File: ecc_ctrl_pkg.sv
package ecc_ctrl_pkg;

    // ==================================================
    // sequencer states and cycle constants
    // ==================================================

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_FIX_Q  = 3'd1,
        ST_FIX_2Q = 3'd2,
        ST_LOAD   = 3'd3,
        ST_LADDER = 3'd4,
        ST_DONE   = 3'd5
    } ladder_state_t;

    // width of the ladder step counter, holds up to LADDER_BITS-1
    localparam int STEP_CNT_W = 6;

    // start edge to first done cycle
    // fix_q, fix_2q and load take three edges, then one edge per ladder bit
    localparam int LATENCY_CYCLES = ecc_params_pkg::LADDER_BITS + 3;

endpackage

// File: ladder_if.sv
`timescale 1ns/1ps

// step commands from the sequencer to the ladder datapath
interface ladder_if;
    import ecc_params_pkg::*;

    // one cycle, clears R0 and loads the base point into R1
    logic                load;
    // held high for each ladder cycle
    logic                step;
    // current scalar bit, msb first
    logic                key_bit;
    // value R0 takes on this edge, used to latch the result
    logic [REG_SIZE-1:0] r0;

    modport ctrl (
        output load,
        output step,
        output key_bit,
        input  r0
    );

    modport dp (
        input  load,
        input  step,
        input  key_bit,
        output r0
    );

endinterface

// File: ecc_mod_add.sv
`timescale 1ns/1ps

// combinational adder modulo q
// both inputs must already be reduced below q
module ecc_mod_add (
    input  logic [ecc_params_pkg::REG_SIZE-1:0] a,
    input  logic [ecc_params_pkg::REG_SIZE-1:0] b,
    output logic [ecc_params_pkg::REG_SIZE-1:0] sum
);
    import ecc_params_pkg::*;

    // full sum with carry
    logic [REG_SIZE:0]   sum_full;
    // sum minus q, low bits only
    logic [REG_SIZE-1:0] sum_red;
    // sum reached q or beyond
    logic                ge_q;

    assign sum_full = {1'b0, a} + {1'b0, b};

    assign ge_q = (sum_full >= {1'b0, GROUP_ORDER});

    // when ge_q the true difference is below q < 2^REG_SIZE,
    // so the wrap of the low-bit subtraction drops only the carry
    assign sum_red = sum_full[REG_SIZE-1:0] - GROUP_ORDER;

    // one conditional subtract is enough, a+b < 2q
    assign sum = ge_q ? sum_red : sum_full[REG_SIZE-1:0];

endmodule

// File: ecc_fixed_msb.sv
`timescale 1ns/1ps

// fixed-msb scalar conditioner
// k < q is replaced by k+q or k+2q, whichever has bit REG_SIZE set,
// so the ladder length never depends on the leading bit of k
module ecc_fixed_msb (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          en,
    input  logic [ecc_params_pkg::REG_SIZE-1:0] data_in,
    output logic [ecc_params_pkg::REG_SIZE:0]   data_out
);
    import ecc_params_pkg::*;

    // k+q needs one extra bit, k+2q needs two
    logic [REG_SIZE:0]   data_q;
    logic [REG_SIZE:0]   data_q_reg;
    logic [REG_SIZE+1:0] data_2q;
    logic [REG_SIZE+1:0] data_2q_reg;

    // ==================================================
    // adders
    // ==================================================

    // first stage works on the raw scalar
    assign data_q = {1'b0, data_in} + {1'b0, GROUP_ORDER};

    // second stage adds q once more to the registered k+q
    assign data_2q = {1'b0, data_q_reg} + {2'b00, GROUP_ORDER};

    // ==================================================
    // stage registers
    // ==================================================

    // first enabled edge holds k+q, second one then holds k+2q
    // scalar is stable while en is high, so k+q is simply rewritten
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            data_q_reg  <= '0;
            data_2q_reg <= '0;
        end else if (en) begin
            data_q_reg  <= data_q;
            data_2q_reg <= data_2q;
        end
    end

    // ==================================================
    // output select
    // ==================================================

    // k+q already reaches bit REG_SIZE -> take it
    // otherwise k+q < 2^REG_SIZE and q >= 2^(REG_SIZE-1),
    // so k+2q sits in [2^REG_SIZE, 2^(REG_SIZE+1)) and its low bits fit
    assign data_out = data_q_reg[REG_SIZE] ? data_q_reg : data_2q_reg[REG_SIZE:0];

endmodule

// File: ecc_ladder_dp.sv
`timescale 1ns/1ps

// montgomery ladder datapath, registers R0 and R1
// invariant R1 - R0 = P, so every step is one add and one double
module ecc_ladder_dp (
    input  logic                                clk,
    input  logic                                reset_n,
    ladder_if.dp                                lad,
    input  logic [ecc_params_pkg::REG_SIZE-1:0] base
);
    import ecc_params_pkg::*;

    logic [REG_SIZE-1:0] r0_reg;
    logic [REG_SIZE-1:0] r1_reg;
    logic [REG_SIZE-1:0] r0_nxt;
    logic [REG_SIZE-1:0] r1_nxt;

    // adder outputs
    logic [REG_SIZE-1:0] add_sum;
    logic [REG_SIZE-1:0] dbl_in;
    logic [REG_SIZE-1:0] dbl_sum;

    // ==================================================
    // arithmetic
    // ==================================================

    // R0 + R1
    ecc_mod_add u_add (
        .a   (r0_reg),
        .b   (r1_reg),
        .sum (add_sum)
    );

    // key bit picks which register is doubled
    assign dbl_in = lad.key_bit ? r1_reg : r0_reg;

    // doubling is the register added to itself
    ecc_mod_add u_dbl (
        .a   (dbl_in),
        .b   (dbl_in),
        .sum (dbl_sum)
    );

    // ==================================================
    // next state of the ladder
    // ==================================================

    always_comb begin
        r0_nxt = r0_reg;
        r1_nxt = r1_reg;
        if (lad.load) begin
            // R0 = 0*P, R1 = 1*P
            r0_nxt = '0;
            r1_nxt = base;
        end else if (lad.step) begin
            if (lad.key_bit) begin
                r0_nxt = add_sum;
                r1_nxt = dbl_sum;
            end else begin
                r1_nxt = add_sum;
                r0_nxt = dbl_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            r0_reg <= '0;
            r1_reg <= '0;
        end else begin
            r0_reg <= r0_nxt;
            r1_reg <= r1_nxt;
        end
    end

    // sequencer latches this on the last step edge, so it sees the final R0
    assign lad.r0 = r0_nxt;

endmodule

// File: ecc_scalar_ctrl.sv
`timescale 1ns/1ps

// scalar multiply sequencer
// idle -> fix_q -> fix_2q -> load -> ladder (LADDER_BITS cycles) -> done
module ecc_scalar_ctrl (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                start,
    input  logic [ecc_params_pkg::REG_SIZE:0]   fixed_scalar,
    output logic                                fix_en,
    ladder_if.ctrl                              lad,
    output logic                                busy,
    output logic                                done,
    output logic [ecc_params_pkg::REG_SIZE-1:0] result
);
    import ecc_params_pkg::*;
    import ecc_ctrl_pkg::*;

    ladder_state_t state;
    ladder_state_t state_nxt;

    // conditioned scalar, shifted left once per ladder step
    logic [LADDER_BITS-1:0] key_sr;
    // ladder steps taken so far
    logic [STEP_CNT_W-1:0]  step_cnt;
    logic                   last_step;

    assign last_step = (step_cnt == STEP_CNT_W'(LADDER_BITS - 1));

    // ==================================================
    // state machine
    // ==================================================

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                // start while busy never reaches here, so it is dropped
                if (start) begin
                    state_nxt = ST_FIX_Q;
                end
            end
            ST_FIX_Q:  state_nxt = ST_FIX_2Q;
            ST_FIX_2Q: state_nxt = ST_LOAD;
            ST_LOAD:   state_nxt = ST_LADDER;
            ST_LADDER: begin
                if (last_step) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE:   state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ==================================================
    // step counter and key shift register
    // ==================================================

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            step_cnt <= '0;
        end else if (state == ST_LOAD) begin
            step_cnt <= '0;
        end else if (state == ST_LADDER) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // conditioner output is valid in LOAD, after its second enabled edge
    always_ff @(posedge clk) begin
        if (state == ST_LOAD) begin
            key_sr <= fixed_scalar;
        end else if (state == ST_LADDER) begin
            key_sr <= {key_sr[LADDER_BITS-2:0], 1'b0};
        end
    end

    // result holds until the next run finishes
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            result <= '0;
        end else if (state == ST_LADDER && last_step) begin
            result <= lad.r0;
        end
    end

    // ==================================================
    // outputs
    // ==================================================

    // conditioner runs two edges, k+q then k+2q
    assign fix_en = (state == ST_FIX_Q) || (state == ST_FIX_2Q);

    assign lad.load    = (state == ST_LOAD);
    assign lad.step    = (state == ST_LADDER);
    // msb first
    assign lad.key_bit = key_sr[LADDER_BITS-1];

    assign busy = (state != ST_IDLE);
    assign done = (state == ST_DONE);

endmodule

// File: ecc_scalar_mult_top.sv
`timescale 1ns/1ps

// constant-time scalar multiplier, k*P in the additive group mod q
// fixed latency of LATENCY_CYCLES from start to done
module ecc_scalar_mult_top (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                start,
    input  logic [ecc_params_pkg::REG_SIZE-1:0] scalar,
    input  logic [ecc_params_pkg::REG_SIZE-1:0] base,
    output logic                                busy,
    output logic                                done,
    output logic [ecc_params_pkg::REG_SIZE-1:0] result
);
    import ecc_params_pkg::*;

    // conditioner control and output
    logic              fix_en;
    logic [REG_SIZE:0] fixed_scalar;

    // sequencer to datapath commands
    ladder_if lad ();

    // ==================================================
    // scalar conditioner
    // ==================================================

    ecc_fixed_msb u_fixed_msb (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (fix_en),
        .data_in  (scalar),
        .data_out (fixed_scalar)
    );

    // ==================================================
    // sequencer
    // ==================================================

    ecc_scalar_ctrl u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .start        (start),
        .fixed_scalar (fixed_scalar),
        .fix_en       (fix_en),
        .lad          (lad.ctrl),
        .busy         (busy),
        .done         (done),
        .result       (result)
    );

    // ==================================================
    // ladder datapath
    // ==================================================

    ecc_ladder_dp u_dp (
        .clk     (clk),
        .reset_n (reset_n),
        .lad     (lad.dp),
        .base    (base)
    );

endmodule

// File: ecc_scalar_mult_props.sv
`timescale 1ns/1ps

// sequencer properties, bound into ecc_scalar_ctrl
module ecc_scalar_mult_props (
    input logic                              clk,
    input logic                              reset_n,
    input logic                              start,
    input logic                              busy,
    input logic                              done,
    input ecc_ctrl_pkg::ladder_state_t       state,
    input logic [ecc_params_pkg::REG_SIZE:0] fixed_scalar
);
    import ecc_params_pkg::*;
    import ecc_ctrl_pkg::*;

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // conditioned scalar always has bit REG_SIZE set when it is loaded
    a_fixed_msb: assert property (@(posedge clk) disable iff (!reset_n)
        (state == ST_LOAD) |-> fixed_scalar[REG_SIZE])
        else $error("conditioned scalar msb low in LOAD");

    // accepted start at edge 0, done sampled high one edge after edge LATENCY_CYCLES
    a_latency: assert property (@(posedge clk) disable iff (!reset_n)
        (state == ST_IDLE && start) |-> ##(LATENCY_CYCLES + 1) done)
        else $error("done did not follow start after the fixed latency");

    a_reset_idle: assert property (@(posedge clk)
        !reset_n |=> (!busy && !done))
        else $error("busy or done high after reset");

endmodule

bind ecc_scalar_ctrl ecc_scalar_mult_props u_props (
    .clk          (clk),
    .reset_n      (reset_n),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .state        (state),
    .fixed_scalar (fixed_scalar)
);

// File: tb_ecc_scalar_mult.sv
`timescale 1ns/1ps

// directed tests for the constant-time scalar multiplier
module tb_ecc_scalar_mult;
    import ecc_params_pkg::*;
    import ecc_ctrl_pkg::*;

    // about 40 runs of about 40 cycles each, with margin for reset and gaps
    localparam int MAX_CYCLES = 3000;
    localparam logic [31:0] SEED = 32'h6fe5a8b2;

    logic                clk;
    logic                reset_n;
    logic                start;
    logic [REG_SIZE-1:0] scalar;
    logic [REG_SIZE-1:0] base;
    logic                busy;
    logic                done;
    logic [REG_SIZE-1:0] result;

    int n_checks;
    int n_errors;
    int cycle_cnt;

    ecc_scalar_mult_top DUT (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (start),
        .scalar  (scalar),
        .base    (base),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

    // ==================================================
    // clock and watchdog
    // ==================================================

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, no end of test after %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // ==================================================
    // model, check and drivers
    // ==================================================

    // k*P mod q straight from the group definition, in double width
    function automatic logic [REG_SIZE-1:0] model_mult(input logic [REG_SIZE-1:0] k,
                                                        input logic [REG_SIZE-1:0] p);
        logic [2*REG_SIZE-1:0] prod;
        prod = {{REG_SIZE{1'b0}}, k} * {{REG_SIZE{1'b0}}, p};
        prod = prod % {{REG_SIZE{1'b0}}, GROUP_ORDER};
        return prod[REG_SIZE-1:0];
    endfunction

    task automatic check_eq(input string name, input logic [REG_SIZE-1:0] expected,
                            input logic [REG_SIZE-1:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // pulse start for one edge, returns on the negedge after edge 0
    task automatic launch(input logic [REG_SIZE-1:0] k, input logic [REG_SIZE-1:0] p);
        // wait out the DONE cycle, a start there would be dropped
        while (busy) begin
            @(negedge clk);
        end
        scalar = k;
        base   = p;
        start  = 1'b1;
        @(negedge clk);
        start  = 1'b0;
    endtask

    // counts edges until done is seen, watchdog covers a missing done
    task automatic wait_done(output int lat);
        lat = 0;
        while (!done) begin
            @(negedge clk);
            lat++;
        end
    endtask

    task automatic run_mult(input logic [REG_SIZE-1:0] k, input logic [REG_SIZE-1:0] p,
                            output logic [REG_SIZE-1:0] res, output int lat);
        launch(k, p);
        wait_done(lat);
        res = result;
    endtask

    // ==================================================
    // tests
    // ==================================================

    task automatic test_reset();
        check_eq("busy", '0, REG_SIZE'(busy));
        check_eq("done", '0, REG_SIZE'(done));
        check_eq("result", '0, result);
    endtask

    // k=0 takes the k+2q branch, k=q-1 the k+q branch
    task automatic test_edge_scalars();
        logic [REG_SIZE-1:0] k_list [7];
        logic [REG_SIZE-1:0] p;
        logic [REG_SIZE-1:0] res;
        int lat;
        k_list = '{32'd0, 32'd1, GROUP_ORDER - 1, 32'd2, 32'd3, 32'd5, 32'd7};
        p = 32'h1234_5679;
        foreach (k_list[i]) begin
            run_mult(k_list[i], p, res, lat);
            check_eq("result", model_mult(k_list[i], p), res);
        end
        // largest operands, every add wraps
        run_mult(GROUP_ORDER - 1, GROUP_ORDER - 1, res, lat);
        check_eq("result", model_mult(GROUP_ORDER - 1, GROUP_ORDER - 1), res);
    endtask

    task automatic test_random();
        logic [REG_SIZE-1:0] k;
        logic [REG_SIZE-1:0] p;
        logic [REG_SIZE-1:0] res;
        int lat;
        for (int i = 0; i < 25; i++) begin
            k = $urandom % GROUP_ORDER;
            p = $urandom % GROUP_ORDER;
            run_mult(k, p, res, lat);
            check_eq("result", model_mult(k, p), res);
        end
    endtask

    // latency must not depend on k
    task automatic test_latency();
        logic [REG_SIZE-1:0] k_list [3];
        logic [REG_SIZE-1:0] res;
        int lat;
        k_list = '{32'd0, 32'd1, GROUP_ORDER - 1};
        foreach (k_list[i]) begin
            run_mult(k_list[i], 32'h0000_0abc, res, lat);
            check_eq("latency", REG_SIZE'(LATENCY_CYCLES), REG_SIZE'(lat));
        end
    endtask

    task automatic test_start_busy();
        logic [REG_SIZE-1:0] k;
        logic [REG_SIZE-1:0] p;
        int lat;
        k = 32'h8000_1234;
        p = 32'h0bad_cafe;
        launch(k, p);
        repeat (10) @(negedge clk);
        // second request with other operands, mid ladder
        scalar = 32'h0000_0042;
        base   = 32'h0000_0099;
        start  = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        wait_done(lat);
        check_eq("latency", REG_SIZE'(LATENCY_CYCLES), REG_SIZE'(lat + 11));
        check_eq("result", model_mult(k, p), result);
        @(negedge clk);
        // no second run was queued
        check_eq("busy", '0, REG_SIZE'(busy));
    endtask

    task automatic test_back_to_back();
        logic [REG_SIZE-1:0] k;
        logic [REG_SIZE-1:0] p;
        logic [REG_SIZE-1:0] res;
        int lat;
        for (int i = 0; i < 3; i++) begin
            k = $urandom % GROUP_ORDER;
            p = $urandom % GROUP_ORDER;
            run_mult(k, p, res, lat);
            check_eq("result", model_mult(k, p), res);
            // result holds while idle
            repeat (2) @(negedge clk);
            check_eq("result", model_mult(k, p), result);
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b0;
        start     = 1'b0;
        scalar    = '0;
        base      = '0;
        n_checks  = 0;
        n_errors  = 0;
        cycle_cnt = 0;
        void'($urandom(SEED));
        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        test_reset();
        test_edge_scalars();
        test_random();
        test_latency();
        test_start_busy();
        test_back_to_back();

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
ecc_params_pkg.sv
ecc_ctrl_pkg.sv
ladder_if.sv
ecc_mod_add.sv
ecc_fixed_msb.sv
ecc_ladder_dp.sv
ecc_scalar_ctrl.sv
ecc_scalar_mult_top.sv
ecc_scalar_mult_props.sv
tb_ecc_scalar_mult.sv

// File: run.sh
#!/bin/sh
# build and run the scalar multiplier testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ecc_scalar_mult -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ecc_scalar_mult > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# verdict comes from the log
if grep -q "tests failed" "$LOG"; then
    exit 1
fi
exit 0
